// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = tbLaneStats
FILELIST  = filelist.f
PASSMSG   = PASS: all tests
SIM       = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: captureSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "laneStats_config.svh"

module captureSequencer (
    input  wire                     sys_clk,
    input  wire                     rst,
    input  wire                     startValid,
    input  wire [`WINDOW_WIDTH-1:0] startWindow,
    input  wire                     sampleFire,
    input  wire                     drainDone,
    output logic                    startReady,
    output logic                    clearAll,
    output logic                    collect,
    output logic                    drainGo,
    output logic                    busy,
    output logic                    done
);

    localparam logic [`WINDOW_WIDTH-1:0] lastSample = 1;

    laneStatsPkg::seqState_e state;
    laneStatsPkg::seqState_e nextState;
    logic [`WINDOW_WIDTH-1:0] remaining;   // Samples left in window
    logic                     startFire;

    assign startFire = startValid && startReady;
    assign clearAll  = (state == laneStatsPkg::Arm);
    assign collect   = (state == laneStatsPkg::Collect);
    assign busy      = (state != laneStatsPkg::Idle) && (state != laneStatsPkg::Done);

    always_comb begin
        nextState = state;
        unique case (state)
            laneStatsPkg::Idle: begin
                if (startFire) nextState = laneStatsPkg::Arm;
            end
            laneStatsPkg::Arm: begin
                // Empty window skips collection
                nextState = (remaining == '0) ? laneStatsPkg::Drain : laneStatsPkg::Collect;
            end
            laneStatsPkg::Collect: begin
                if (sampleFire && remaining == lastSample) nextState = laneStatsPkg::Drain;
            end
            laneStatsPkg::Drain: begin
                if (drainDone) nextState = laneStatsPkg::Done;
            end
            laneStatsPkg::Done: begin
                nextState = laneStatsPkg::Idle;
            end
            default: nextState = laneStatsPkg::Idle;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state      <= laneStatsPkg::Idle;
            startReady <= 1'b0;
            drainGo    <= 1'b0;
            done       <= 1'b0;
        end else begin
            state      <= nextState;
            startReady <= (nextState == laneStatsPkg::Idle);
            drainGo    <= (nextState == laneStatsPkg::Drain) && (state != laneStatsPkg::Drain);
            done       <= (nextState == laneStatsPkg::Done);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (startFire) begin
            remaining <= startWindow;
        end else if (collect && sampleFire) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Readout owns the exit from Drain
    assert property (@(posedge sys_clk) disable iff (rst)
        drainDone |-> state == laneStatsPkg::Drain);

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
laneStatsPkg.sv
laneReadIf.sv
captureSequencer.sv
laneAccumulator.sv
resultReadout.sv
laneStatsTop.sv
tbChecker.sv
tbLaneStats.sv

// File: laneAccumulator.sv
`timescale 1ns/1ps
`default_nettype none

`include "laneStats_config.svh"

module laneAccumulator (
    input  wire                     sys_clk,
    input  wire                     rst,
    input  wire                     clearAll,
    input  wire                     collect,
    input  wire                     sampleValid,
    input  wire [`LANE_BITS-1:0]    sampleLane,
    input  wire [`SAMPLE_WIDTH-1:0] sampleValue,
    output logic                    sampleReady,
    output logic                    sampleFire,
    laneReadIf.bank                 rdPort
);

    laneStatsPkg::laneResult_t laneTable [`LANE_COUNT];
    logic [`SUM_WIDTH-1:0]     sampleExt;

    // Never back-pressured while collecting
    assign sampleReady = collect;
    assign sampleFire  = sampleValid && sampleReady;
    assign sampleExt   = {{(`SUM_WIDTH - `SAMPLE_WIDTH){1'b0}}, sampleValue};

    always_ff @(posedge sys_clk) begin
        if (rst || clearAll) begin
            for (int i = 0; i < `LANE_COUNT; i++) begin
                laneTable[i] <= '0;
            end
        end else if (sampleFire) begin
            laneTable[sampleLane].sum <= laneTable[sampleLane].sum + sampleExt;
            if (&laneTable[sampleLane].count) begin
                laneTable[sampleLane].satFlag <= 1'b1;   // Count stays pinned
            end else begin
                laneTable[sampleLane].count <= laneTable[sampleLane].count + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rdPort.rdValid <= 1'b0;
        end else begin
            rdPort.rdValid <= rdPort.rdEn;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rdPort.rdEn) begin
            rdPort.rdData <= laneTable[rdPort.rdLane];
        end
    end

    // Sequencer keeps clear and collection apart
    assert property (@(posedge sys_clk) disable iff (rst)
        sampleFire |-> !clearAll);

    for (genvar g = 0; g < `LANE_COUNT; g++) begin : genCountCheck
        assert property (@(posedge sys_clk) disable iff (rst)
            !clearAll |=> laneTable[g].count >= $past(laneTable[g].count));
    end

endmodule

`default_nettype wire

// File: laneCases.txt
# Case blocks: C <window> <stall none|random>, closed by E
# Samples: S <lane> <hex value> <repeat count>
C 12 none
S 0 0001 1
S 3 ffff 2
S 7 1234 1
S 15 abcd 3
S 3 0010 1
S 9 8000 2
S 0 00ff 2
E
# Lane 5 overflows its count
C 262 none
S 5 ffff 260
S 2 0042 2
E
# Result stream stalls
C 20 random
S 1 0101 4
S 4 beef 5
S 14 7fff 6
S 15 0003 5
E
# New start after a busy case
C 3 random
S 8 0020 3
E
# Empty window with samples offered
C 0 none
S 6 1111 2
E
# Samples offered past the window
C 5 none
S 11 0a0a 4
S 12 0b0b 4
E
C 30 random
S 13 ffff 30
S 0 0001 2
E

// File: laneReadIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "laneStats_config.svh"

interface laneReadIf;

    logic                      rdEn;
    logic [`LANE_BITS-1:0]     rdLane;
    laneStatsPkg::laneResult_t rdData;    // Valid one cycle after rdEn
    logic                      rdValid;

    modport reader (
        output rdEn,
        output rdLane,
        input  rdData,
        input  rdValid
    );

    modport bank (
        input  rdEn,
        input  rdLane,
        output rdData,
        output rdValid
    );

endinterface

`default_nettype wire

// File: laneStatsPkg.sv
`default_nettype none

`include "laneStats_config.svh"

package laneStatsPkg;

    // Command sequencer states
    typedef enum logic [2:0] {
        Idle    = 3'd0,
        Arm     = 3'd1,   // Clear all lanes
        Collect = 3'd2,
        Drain   = 3'd3,   // Result walk in progress
        Done    = 3'd4
    } seqState_e;

    // One lane entry of the accumulator bank
    typedef struct packed {
        logic [`SUM_WIDTH-1:0]   sum;
        logic [`COUNT_WIDTH-1:0] count;
        logic                    satFlag;   // Sticky count overflow
    } laneResult_t;

endpackage

`default_nettype wire

// File: laneStatsTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "laneStats_config.svh"

module laneStatsTop (
    input  wire                     sys_clk,
    input  wire                     rst,
    input  wire                     startValid,
    input  wire [`WINDOW_WIDTH-1:0] startWindow,
    output logic                    startReady,
    input  wire                     sampleValid,
    input  wire [`LANE_BITS-1:0]    sampleLane,
    input  wire [`SAMPLE_WIDTH-1:0] sampleValue,
    output logic                    sampleReady,
    output logic                    resValid,
    input  wire                     resReady,
    output logic [`LANE_BITS-1:0]   resLane,
    output logic [`SUM_WIDTH-1:0]   resSum,
    output logic [`COUNT_WIDTH-1:0] resCount,
    output logic                    resSat,
    output logic                    busy,
    output logic                    done
);

    logic clearAll;
    logic collect;
    logic drainGo;
    logic drainDone;
    logic sampleFire;

    laneReadIf rdBus ();   // Bank to readout

    captureSequencer i_sequencer (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .startValid  (startValid),
        .startWindow (startWindow),
        .sampleFire  (sampleFire),
        .drainDone   (drainDone),
        .startReady  (startReady),
        .clearAll    (clearAll),
        .collect     (collect),
        .drainGo     (drainGo),
        .busy        (busy),
        .done        (done)
    );

    laneAccumulator i_accumulator (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .clearAll    (clearAll),
        .collect     (collect),
        .sampleValid (sampleValid),
        .sampleLane  (sampleLane),
        .sampleValue (sampleValue),
        .sampleReady (sampleReady),
        .sampleFire  (sampleFire),
        .rdPort      (rdBus.bank)
    );

    resultReadout i_readout (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .drainGo   (drainGo),
        .resReady  (resReady),
        .resValid  (resValid),
        .resLane   (resLane),
        .resSum    (resSum),
        .resCount  (resCount),
        .resSat    (resSat),
        .drainDone (drainDone),
        .rdPort    (rdBus.reader)
    );

endmodule

`default_nettype wire

// File: laneStats_config.svh
`ifndef LANE_STATS_CONFIG_SVH
`define LANE_STATS_CONFIG_SVH

`define LANE_COUNT     16
`define LANE_BITS      4
`define SAMPLE_WIDTH   16
`define SUM_WIDTH      64
`define COUNT_WIDTH    8   // Saturates at all ones
`define WINDOW_WIDTH   16

// Watchdog cycles per sample or lane
`define TIMEOUT_MARGIN 8

`endif

// File: resultReadout.sv
`timescale 1ns/1ps
`default_nettype none

`include "laneStats_config.svh"

module resultReadout (
    input  wire                     sys_clk,
    input  wire                     rst,
    input  wire                     drainGo,
    input  wire                     resReady,
    output logic                    resValid,
    output logic [`LANE_BITS-1:0]   resLane,
    output logic [`SUM_WIDTH-1:0]   resSum,
    output logic [`COUNT_WIDTH-1:0] resCount,
    output logic                    resSat,
    output logic                    drainDone,
    laneReadIf.reader               rdPort
);

    localparam int laneMax = `LANE_COUNT - 1;

    logic [`LANE_BITS-1:0]     laneIdx;    // Lane currently presented
    laneStatsPkg::laneResult_t resEntry;
    logic                      resFire;
    logic                      lastLane;

    assign resFire  = resValid && resReady;
    assign lastLane = (laneIdx == laneMax[`LANE_BITS-1:0]);

    // Next read only once the current result is taken
    assign rdPort.rdEn   = drainGo || (resFire && !lastLane);
    assign rdPort.rdLane = drainGo ? '0 : laneIdx + 1'b1;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            laneIdx   <= '0;
            resValid  <= 1'b0;
            drainDone <= 1'b0;
        end else begin
            drainDone <= resFire && lastLane;
            if (drainGo) begin
                laneIdx <= '0;
            end else if (resFire && !lastLane) begin
                laneIdx <= laneIdx + 1'b1;
            end
            if (rdPort.rdValid) begin
                resValid <= 1'b1;
            end else if (resFire) begin
                resValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rdPort.rdValid) begin
            resEntry <= rdPort.rdData;
        end
    end

    assign resLane  = laneIdx;
    assign resSum   = resEntry.sum;
    assign resCount = resEntry.count;
    assign resSat   = resEntry.satFlag;

    assert property (@(posedge sys_clk) disable iff (rst)
        (resValid && !resReady) |=> resValid && $stable(resLane) && $stable(resSum)
            && $stable(resCount) && $stable(resSat));

endmodule

`default_nettype wire

// File: tbChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "laneStats_config.svh"

module tbChecker (
    input  wire                     sys_clk,
    input  wire                     rst,
    input  wire                     startValid,
    input  wire [`WINDOW_WIDTH-1:0] startWindow,
    input  wire                     startReady,
    input  wire                     sampleValid,
    input  wire [`LANE_BITS-1:0]    sampleLane,
    input  wire [`SAMPLE_WIDTH-1:0] sampleValue,
    input  wire                     sampleReady,
    input  wire                     resValid,
    input  wire                     resReady,
    input  wire [`LANE_BITS-1:0]    resLane,
    input  wire [`SUM_WIDTH-1:0]    resSum,
    input  wire [`COUNT_WIDTH-1:0]  resCount,
    input  wire                     resSat,
    input  wire                     busy,
    input  wire                     done,
    output int                      caseCount,
    output int                      failedCases,
    output int                      errTotal
);

    logic [`SUM_WIDTH-1:0]    expSum [`LANE_COUNT];
    logic [`COUNT_WIDTH-1:0]  expCnt [`LANE_COUNT];
    logic                     expSat [`LANE_COUNT];
    logic [`WINDOW_WIDTH-1:0] window;
    logic [`WINDOW_WIDTH-1:0] fires;
    logic [`LANE_BITS:0]      lanesSeen;
    logic [`LANE_BITS-1:0]    heldLane;
    logic [`SUM_WIDTH-1:0]    heldSum;
    logic [`COUNT_WIDTH-1:0]  heldCount;
    logic                     heldSat;
    logic prevRst, prevBusy, prevStartFire, prevStall, checkReady, caseOpen;
    int   caseErrs;

    task automatic reportValue(input string name, input logic [63:0] expVal,
                               input logic [63:0] actVal);
        $display("Fail %s: expected %h, got %h", name, expVal, actVal);
        caseErrs++;
        errTotal++;
    endtask

    task automatic reportProblem(input string text);
        $display("Error: %s", text);
        caseErrs++;
        errTotal++;
    endtask

    initial begin
        caseCount = 0;
        failedCases = 0;
        errTotal = 0;
        caseErrs = 0;
        caseOpen = 0;
        checkReady = 0;
        prevRst = 1;
    end

    always @(posedge sys_clk) begin
        if (rst) begin
            prevRst = 1;
            prevBusy = 0;
            prevStartFire = 0;
            prevStall = 0;
        end else begin
            if (prevRst) begin   // Values held during the last reset cycle
                if (busy || done || resValid || sampleReady || startReady)
                    reportProblem("outputs not all low while in reset");
                checkReady = 1;
            end else if (checkReady) begin
                if (!startReady) reportProblem("startReady did not rise after reset");
                checkReady = 0;
            end
            prevRst = 0;
            if (busy && !prevBusy && !prevStartFire)
                reportProblem("busy rose without an accepted start");
            if (caseOpen && busy == done)
                reportProblem("busy was not high from start until done");
            if (startValid && startReady) begin
                for (int i = 0; i < `LANE_COUNT; i++) begin
                    expSum[i] = '0;
                    expCnt[i] = '0;
                    expSat[i] = 1'b0;
                end
                window = startWindow;
                fires = '0;
                lanesSeen = '0;
                caseErrs = 0;
                caseOpen = 1;
            end
            if (sampleValid && sampleReady) begin
                expSum[sampleLane] = expSum[sampleLane] + 64'(sampleValue);
                if (&expCnt[sampleLane]) expSat[sampleLane] = 1'b1;
                else expCnt[sampleLane] = expCnt[sampleLane] + 1'b1;
                fires = fires + 1'b1;
            end
            if (prevStall) begin   // Data must hold while stalled
                if (!resValid) reportProblem("resValid dropped before resReady");
                if (resLane != heldLane) reportValue("resLane", 64'(heldLane), 64'(resLane));
                if (resSum != heldSum) reportValue("resSum", heldSum, resSum);
                if (resCount != heldCount) reportValue("resCount", 64'(heldCount), 64'(resCount));
                if (resSat != heldSat) reportValue("resSat", 64'(heldSat), 64'(resSat));
            end
            if (resValid && resReady) begin
                if (lanesSeen >= `LANE_COUNT) begin
                    reportProblem("result accepted after lane 15");
                end else begin
                    if (resLane != lanesSeen[`LANE_BITS-1:0])
                        reportValue("resLane", 64'(lanesSeen), 64'(resLane));
                    if (resSum != expSum[lanesSeen[`LANE_BITS-1:0]])
                        reportValue("resSum", expSum[lanesSeen[`LANE_BITS-1:0]], resSum);
                    if (resCount != expCnt[lanesSeen[`LANE_BITS-1:0]])
                        reportValue("resCount", 64'(expCnt[lanesSeen[`LANE_BITS-1:0]]),
                                    64'(resCount));
                    if (resSat != expSat[lanesSeen[`LANE_BITS-1:0]])
                        reportValue("resSat", 64'(expSat[lanesSeen[`LANE_BITS-1:0]]),
                                    64'(resSat));
                    lanesSeen = lanesSeen + 1'b1;
                end
            end
            if (done) begin
                if (!caseOpen) begin
                    reportProblem("done pulsed with no case running");
                end else begin
                    if (lanesSeen != `LANE_COUNT)
                        reportProblem("done came before all lanes were accepted");
                    if (fires != window) reportValue("sampleFires", 64'(window), 64'(fires));
                    caseCount++;
                    if (caseErrs == 0) begin
                        $display("Case %0d window %0d: ok", caseCount, window);
                    end else begin
                        $display("Case %0d window %0d: %0d errors", caseCount, window, caseErrs);
                        failedCases++;
                    end
                    caseOpen = 0;
                end
            end
            prevStall = resValid && !resReady;
            heldLane = resLane;
            heldSum = resSum;
            heldCount = resCount;
            heldSat = resSat;
            prevBusy = busy;
            prevStartFire = startValid && startReady;
        end
    end

endmodule

`default_nettype wire

// File: tbLaneStats.sv
`timescale 1ns/1ps
`default_nettype none

`include "laneStats_config.svh"

module tbLaneStats;

    logic                     sys_clk;
    logic                     rst;
    logic                     startValid;
    logic [`WINDOW_WIDTH-1:0] startWindow;
    logic                     startReady;
    logic                     sampleValid;
    logic [`LANE_BITS-1:0]    sampleLane;
    logic [`SAMPLE_WIDTH-1:0] sampleValue;
    logic                     sampleReady;
    logic                     resValid;
    logic                     resReady;
    logic [`LANE_BITS-1:0]    resLane;
    logic [`SUM_WIDTH-1:0]    resSum;
    logic [`COUNT_WIDTH-1:0]  resCount;
    logic                     resSat;
    logic                     busy;
    logic                     done;
    int caseCount, failedCases, errTotal;

    logic [`WINDOW_WIDTH-1:0] caseWin [$];
    logic                     caseStall [$];
    int                       caseFirst [$];
    int                       caseLen [$];
    logic [`LANE_BITS-1:0]    sampLane [$];
    logic [`SAMPLE_WIDTH-1:0] sampVal [$];
    logic [31:0]              lfsr;
    logic                     stallMode;
    longint                   watchLimit;

    laneStatsTop i_dut (.*);

    tbChecker i_checker (.*);

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic loadCases();
        int fd, n, a, b, c;
        string line, tag, mode;
        fd = $fopen("laneCases.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open laneCases.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s", tag);
                if (n == 1 && tag == "C") begin
                    n = $sscanf(line, "%s %d %s", tag, a, mode);
                    caseWin.push_back(a[`WINDOW_WIDTH-1:0]);
                    caseStall.push_back(mode == "random");
                    caseFirst.push_back(sampLane.size());
                end else if (n == 1 && tag == "S") begin
                    n = $sscanf(line, "%s %d %h %d", tag, a, b, c);
                    for (int i = 0; i < c; i++) begin   // Repeat count expands here
                        sampLane.push_back(a[`LANE_BITS-1:0]);
                        sampVal.push_back(b[`SAMPLE_WIDTH-1:0]);
                    end
                end else if (n == 1 && tag == "E") begin
                    caseLen.push_back(sampLane.size() - caseFirst[caseFirst.size() - 1]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runCase(input int idx);
        int accepted;
        accepted = 0;
        // Start is offered before startReady rises
        startValid = 1'b1;
        startWindow = caseWin[idx];
        stallMode = caseStall[idx];
        while (!startReady) @(negedge sys_clk);
        @(negedge sys_clk);
        startValid = 1'b0;
        for (int s = caseFirst[idx]; s < caseFirst[idx] + caseLen[idx]; s++) begin
            sampleValid = 1'b1;
            sampleLane = sampLane[s];
            sampleValue = sampVal[s];
            if (accepted < int'(caseWin[idx])) begin
                while (!sampleReady) @(negedge sys_clk);
                accepted++;
            end
            @(negedge sys_clk);   // Extras get one refused cycle each
        end
        sampleValid = 1'b0;
        while (!done) @(negedge sys_clk);
    endtask

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    always @(negedge sys_clk) begin
        if (stallMode) begin
            lfsr = stepLfsr(lfsr);
            resReady = lfsr[0];
        end else begin
            resReady = 1'b1;
        end
    end

    initial begin
        wait (watchLimit != 0);
        #(watchLimit * 40);
        $display("Timeout: the run did not finish in the expected time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst = 1'b1;
        startValid = 1'b0;
        startWindow = '0;
        sampleValid = 1'b0;
        sampleLane = '0;
        sampleValue = '0;
        resReady = 1'b0;
        stallMode = 1'b0;
        lfsr = 32'd96945;
        watchLimit = 0;
        loadCases();
        watchLimit = 10;
        foreach (caseLen[i]) watchLimit += caseLen[i] + `LANE_COUNT;
        watchLimit = watchLimit * `TIMEOUT_MARGIN;
        repeat (10) @(negedge sys_clk);
        rst = 1'b0;
        foreach (caseWin[i]) runCase(i);
        repeat (2) @(negedge sys_clk);
        $display("Cases %0d, failed %0d, errors %0d", caseCount, failedCases, errTotal);
        if (errTotal == 0 && caseCount == caseWin.size() && caseWin.size() > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
